/* hw/coreLitePkg.sv */
package coreLitePkg;

	// Datapath widths
	localparam int XLEN = 32;
	localparam int REGADDRW = 5;

	// RV32I major opcodes handled by this slice
	localparam logic [6:0] OPC_OP = 7'b0110011;	// R-type ALU
	localparam logic [6:0] OPC_OPIMM = 7'b0010011;	// I-type ALU and immediate shifts
	localparam logic [6:0] OPC_LUI = 7'b0110111;

	// ALU operation carried from decode to execute
	typedef enum logic [3:0]
	{
		ADD = 4'd0,
		SUB = 4'd1,
		SLL = 4'd2,
		SLT = 4'd3,
		SLTU = 4'd4,
		XOR = 4'd5,
		SRL = 4'd6,
		SRA = 4'd7,
		OR = 4'd8,
		AND = 4'd9,
		PASSB = 4'd10	// Operand B straight through, used by LUI
	} aluOp_t;

	// Operand B source chosen in issue
	typedef enum logic [1:0]
	{
		REG = 2'd0,	// rs2 from the register file
		IMM = 2'd1,	// I-immediate or U-immediate
		SHAMT = 2'd2	// Zero-extended shift amount
	} bSel_t;

endpackage

/* hw/regFile.sv */
module regFile (
	input logic clk,
	input logic nrst,
	input logic we,
	input logic [coreLitePkg::REGADDRW-1:0] wrAddr,
	input logic [coreLitePkg::XLEN-1:0] wrData,
	input logic [coreLitePkg::REGADDRW-1:0] rdAddrA,
	input logic [coreLitePkg::REGADDRW-1:0] rdAddrB,
	output logic [coreLitePkg::XLEN-1:0] rdDataA,
	output logic [coreLitePkg::XLEN-1:0] rdDataB
);

	logic [coreLitePkg::XLEN-1:0] regs [1:31];	// x0 has no storage

	// x0 reads as zero and a same-cycle write is forwarded
	function automatic logic [coreLitePkg::XLEN-1:0] readPort(
		input logic [coreLitePkg::REGADDRW-1:0] addr
	);
		logic [coreLitePkg::XLEN-1:0] data;
		if (addr == '0)
			data = '0;
		else if (we && (wrAddr == addr))
			data = wrData;
		else
			data = regs[addr];
		return data;
	endfunction

	always_comb
	begin
		rdDataA = readPort(rdAddrA);
		rdDataB = readPort(rdAddrB);
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && (wrAddr != '0))
			regs[wrAddr] <= wrData;
	end

endmodule

/* hw/decodeStage.sv */
module decodeStage (
	input logic clk,
	input logic nrst,
	input logic instrValid,
	input logic [31:0] instr,
	output logic decValid,
	output logic [coreLitePkg::REGADDRW-1:0] decRs1,
	output logic [coreLitePkg::REGADDRW-1:0] decRs2,
	output logic [coreLitePkg::REGADDRW-1:0] decRd,
	output coreLitePkg::aluOp_t decAluOp,
	output coreLitePkg::bSel_t decBSel,
	output logic [coreLitePkg::XLEN-1:0] decImm,
	output logic [4:0] decShamt
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [coreLitePkg::XLEN-1:0] iImm;
	logic [coreLitePkg::XLEN-1:0] uImm;

	logic nextValid;
	coreLitePkg::aluOp_t nextAluOp;
	coreLitePkg::bSel_t nextBSel;
	logic [coreLitePkg::XLEN-1:0] nextImm;

	// funct3 to ALU op, bit 30 picks the alternate form where allowed
	function automatic coreLitePkg::aluOp_t aluFromFunct3(
		input logic [2:0] f3,
		input logic subSel,
		input logic sraSel
	);
		coreLitePkg::aluOp_t op;
		unique case (f3)
			3'b000: op = subSel ? coreLitePkg::SUB : coreLitePkg::ADD;
			3'b001: op = coreLitePkg::SLL;
			3'b010: op = coreLitePkg::SLT;
			3'b011: op = coreLitePkg::SLTU;
			3'b100: op = coreLitePkg::XOR;
			3'b101: op = sraSel ? coreLitePkg::SRA : coreLitePkg::SRL;
			3'b110: op = coreLitePkg::OR;
			3'b111: op = coreLitePkg::AND;
		endcase
		return op;
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign iImm = {{20{instr[31]}}, instr[31:20]};	// Sign-extended I-immediate
	assign uImm = {instr[31:12], 12'b0};

	always_comb
	begin
		nextValid = 1'b0;
		nextAluOp = coreLitePkg::ADD;
		nextBSel = coreLitePkg::REG;
		nextImm = iImm;
		unique case (opcode)
			coreLitePkg::OPC_OP:
			begin
				// Only 0000000 and 0100000 on ADD/SUB and SRL/SRA are legal
				nextValid = (funct7 == 7'b0000000) ||
					((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
				nextAluOp = aluFromFunct3(funct3, instr[30], instr[30]);
				nextBSel = coreLitePkg::REG;
			end
			coreLitePkg::OPC_OPIMM:
			begin
				nextValid = 1'b1;
				nextAluOp = aluFromFunct3(funct3, 1'b0, instr[30]);	// No SUBI
				nextBSel = (funct3[1:0] == 2'b01) ? coreLitePkg::SHAMT : coreLitePkg::IMM;
			end
			coreLitePkg::OPC_LUI:
			begin
				nextValid = 1'b1;
				nextAluOp = coreLitePkg::PASSB;
				nextBSel = coreLitePkg::IMM;
				nextImm = uImm;
			end
			default: nextValid = 1'b0;	// Unsupported opcode never commits
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			decValid <= 1'b0;
			decRs1 <= '0;
			decRs2 <= '0;
			decRd <= '0;
			decAluOp <= coreLitePkg::ADD;
			decBSel <= coreLitePkg::REG;
			decImm <= '0;
			decShamt <= '0;
		end
		else
		begin
			decValid <= instrValid && nextValid;
			if (instrValid)
			begin
				decRs1 <= instr[19:15];
				decRs2 <= instr[24:20];
				decRd <= instr[11:7];
				decAluOp <= nextAluOp;
				decBSel <= nextBSel;
				decImm <= nextImm;
				decShamt <= instr[24:20];	// Same bits as rs2 for shifts
			end
		end
	end

endmodule

/* hw/issueStage.sv */
module issueStage (
	input logic clk,
	input logic nrst,
	input logic decValid,
	input logic [coreLitePkg::REGADDRW-1:0] decRs1,
	input logic [coreLitePkg::REGADDRW-1:0] decRs2,
	input logic [coreLitePkg::REGADDRW-1:0] decRd,
	input coreLitePkg::aluOp_t decAluOp,
	input coreLitePkg::bSel_t decBSel,
	input logic [coreLitePkg::XLEN-1:0] decImm,
	input logic [4:0] decShamt,
	input logic wbValid,
	input logic [coreLitePkg::REGADDRW-1:0] wbRd,
	input logic [coreLitePkg::XLEN-1:0] wbData,
	output logic issValid,
	output logic [coreLitePkg::REGADDRW-1:0] issRd,
	output coreLitePkg::aluOp_t issAluOp,
	output logic [coreLitePkg::XLEN-1:0] opA,
	output logic [coreLitePkg::XLEN-1:0] opB
);

	logic rfWe;
	logic [coreLitePkg::XLEN-1:0] rfDataA, rfDataB;	// Combinational reads during decode cycle

	logic [coreLitePkg::XLEN-1:0] rs2Reg;
	logic [coreLitePkg::XLEN-1:0] immReg;
	logic [4:0] shamtReg;
	coreLitePkg::bSel_t bSelReg;

	assign rfWe = wbValid && (wbRd != '0);	// Writeback to x0 is dropped

	regFile regFile_i (
		.clk(clk),
		.nrst(nrst),
		.we(rfWe),
		.wrAddr(wbRd),
		.wrData(wbData),
		.rdAddrA(decRs1),
		.rdAddrB(decRs2),
		.rdDataA(rfDataA),
		.rdDataB(rfDataB)
	);

	// Operands are registered together with control so both reach execute in step
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			issValid <= 1'b0;
			issRd <= '0;
			issAluOp <= coreLitePkg::ADD;
			opA <= '0;
			rs2Reg <= '0;
			immReg <= '0;
			shamtReg <= '0;
			bSelReg <= coreLitePkg::REG;
		end
		else
		begin
			issValid <= decValid;
			issRd <= decRd;
			issAluOp <= decAluOp;
			opA <= rfDataA;
			rs2Reg <= rfDataB;
			immReg <= decImm;
			shamtReg <= decShamt;
			bSelReg <= decBSel;
		end
	end

	always_comb
	begin
		unique case (bSelReg)
			coreLitePkg::IMM: opB = immReg;
			coreLitePkg::SHAMT: opB = {{(coreLitePkg::XLEN-5){1'b0}}, shamtReg};
			default: opB = rs2Reg;
		endcase
	end

endmodule

/* hw/executeStage.sv */
module executeStage (
	input logic clk,
	input logic nrst,
	input logic issValid,
	input logic [coreLitePkg::REGADDRW-1:0] issRd,
	input coreLitePkg::aluOp_t issAluOp,
	input logic [coreLitePkg::XLEN-1:0] opA,
	input logic [coreLitePkg::XLEN-1:0] opB,
	output logic commitValid,
	output logic [coreLitePkg::REGADDRW-1:0] commitRd,
	output logic [coreLitePkg::XLEN-1:0] commitData
);

	logic [4:0] shAmt;
	logic signedLess, unsignedLess;
	logic [coreLitePkg::XLEN-1:0] aluResult;

	assign shAmt = opB[4:0];	// Shifts only look at the low five bits
	assign signedLess = $signed(opA) < $signed(opB);
	assign unsignedLess = opA < opB;

	always_comb
	begin
		unique case (issAluOp)
			coreLitePkg::ADD: aluResult = opA + opB;
			coreLitePkg::SUB: aluResult = opA - opB;
			coreLitePkg::SLL: aluResult = opA << shAmt;
			coreLitePkg::SLT: aluResult = {{(coreLitePkg::XLEN-1){1'b0}}, signedLess};
			coreLitePkg::SLTU: aluResult = {{(coreLitePkg::XLEN-1){1'b0}}, unsignedLess};
			coreLitePkg::XOR: aluResult = opA ^ opB;
			coreLitePkg::SRL: aluResult = opA >> shAmt;
			coreLitePkg::SRA: aluResult = $unsigned($signed(opA) >>> shAmt);
			coreLitePkg::OR: aluResult = opA | opB;
			coreLitePkg::AND: aluResult = opA & opB;
			coreLitePkg::PASSB: aluResult = opB;
			default: aluResult = '0;
		endcase
	end

	// Commit record, also the register file write port
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			commitValid <= 1'b0;
			commitRd <= '0;
			commitData <= '0;
		end
		else
		begin
			commitValid <= issValid;
			commitRd <= issRd;
			commitData <= aluResult;
		end
	end

endmodule

/* hw/coreLite.sv */
module coreLite (
	input logic clk,
	input logic nrst,
	input logic instrValid,
	input logic [31:0] instr,
	output logic commitValid,
	output logic [coreLitePkg::REGADDRW-1:0] commitRd,
	output logic [coreLitePkg::XLEN-1:0] commitData
);

	// Decode to issue
	logic decValid;
	logic [coreLitePkg::REGADDRW-1:0] decRs1, decRs2, decRd;
	coreLitePkg::aluOp_t decAluOp;
	coreLitePkg::bSel_t decBSel;
	logic [coreLitePkg::XLEN-1:0] decImm;
	logic [4:0] decShamt;

	// Issue to execute
	logic issValid;
	logic [coreLitePkg::REGADDRW-1:0] issRd;
	coreLitePkg::aluOp_t issAluOp;
	logic [coreLitePkg::XLEN-1:0] opA, opB;

	decodeStage decodeStage_i (
		.clk(clk),
		.nrst(nrst),
		.instrValid(instrValid),
		.instr(instr),
		.decValid(decValid),
		.decRs1(decRs1),
		.decRs2(decRs2),
		.decRd(decRd),
		.decAluOp(decAluOp),
		.decBSel(decBSel),
		.decImm(decImm),
		.decShamt(decShamt)
	);

	issueStage issueStage_i (
		.clk(clk),
		.nrst(nrst),
		.decValid(decValid),
		.decRs1(decRs1),
		.decRs2(decRs2),
		.decRd(decRd),
		.decAluOp(decAluOp),
		.decBSel(decBSel),
		.decImm(decImm),
		.decShamt(decShamt),
		.wbValid(commitValid),	// Writeback loop from the commit register
		.wbRd(commitRd),
		.wbData(commitData),
		.issValid(issValid),
		.issRd(issRd),
		.issAluOp(issAluOp),
		.opA(opA),
		.opB(opB)
	);

	executeStage executeStage_i (
		.clk(clk),
		.nrst(nrst),
		.issValid(issValid),
		.issRd(issRd),
		.issAluOp(issAluOp),
		.opA(opA),
		.opB(opB),
		.commitValid(commitValid),
		.commitRd(commitRd),
		.commitData(commitData)
	);

endmodule

/* dv/coreLite_sva.sv */
module coreLite_sva (
	input logic clk,
	input logic nrst,
	input logic instrValid,
	input logic [31:0] instr,
	input logic commitValid,
	input logic [coreLitePkg::XLEN-1:0] commitData
);
	timeunit 1ns;
	timeprecision 1ps;

	logic knownInstr;

	// Legal OP funct7 values are 0000000, and 0100000 only for SUB and SRA
	assign knownInstr = (instr[6:0] == coreLitePkg::OPC_OPIMM) ||
		(instr[6:0] == coreLitePkg::OPC_LUI) ||
		((instr[6:0] == coreLitePkg::OPC_OP) && ((instr[31:25] == 7'h00) ||
		((instr[31:25] == 7'h20) && ((instr[14:12] == 3'd0) || (instr[14:12] == 3'd5)))));

	resetQuiet: assert property (@(posedge clk) !nrst |-> !commitValid)
		else $error("commitValid high while in reset");

	fixedLatency: assert property (@(posedge clk) disable iff (!nrst)
		(instrValid && knownInstr) |-> ##3 commitValid)
		else $error("commitValid missing three cycles after a legal instruction");

	dataKnown: assert property (@(posedge clk) disable iff (!nrst)
		commitValid |-> !$isunknown(commitData))
		else $error("commitData has unknown bits during a commit");

endmodule

bind coreLite coreLite_sva coreLite_sva_i (.*);

/* dv/coreLiteTb.sv */
module coreLiteTb;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk, nrst, instrValid;
	logic [31:0] instr;
	logic commitValid;
	logic [4:0] commitRd;
	logic [31:0] commitData;

	logic [31:0] seed;
	logic [31:0] modelRegs [32];	// Architectural state of the reference
	logic [4:0] lastRd [2];	// rd of the last two sampled instructions
	logic [36:0] expQ [$];	// {rd, data} in program order
	string tagQ [$];
	logic [36:0] expRec;
	string expTag;
	int waitCycles;

	coreLite coreLite_i (
		.clk(clk),
		.nrst(nrst),
		.instrValid(instrValid),
		.instr(instr),
		.commitValid(commitValid),
		.commitRd(commitRd),
		.commitData(commitData)
	);

	always #20 clk = ~clk;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			failRun($sformatf("ERR %s expected %08h actual %08h", name, expected, actual));
	endtask

	function automatic logic [31:0] nextRand();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	// RV32I semantics for OP, OP-IMM and LUI, updates the model registers
	function automatic logic refModel(input logic [31:0] ins, output logic [4:0] rd,
		output logic [31:0] data);
		logic [6:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [31:0] a, b;
		logic valid;
		opc = ins[6:0];
		f3 = ins[14:12];
		f7 = ins[31:25];
		rd = ins[11:7];
		a = modelRegs[ins[19:15]];
		b = {{20{ins[31]}}, ins[31:20]};
		valid = 1'b1;
		data = '0;
		if (opc == coreLitePkg::OPC_LUI)
			data = {ins[31:12], 12'h000};
		else if ((opc == coreLitePkg::OPC_OP) || (opc == coreLitePkg::OPC_OPIMM))
		begin
			if (opc == coreLitePkg::OPC_OP)
			begin
				b = modelRegs[ins[24:20]];
				valid = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
			end
			case (f3)
				3'd0: data = ((opc == coreLitePkg::OPC_OP) && ins[30]) ? a - b : a + b;
				3'd1: data = a << b[4:0];
				3'd2: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				3'd3: data = (a < b) ? 32'd1 : 32'd0;
				3'd4: data = a ^ b;
				3'd5: data = ins[30] ? $unsigned($signed(a) >>> b[4:0]) : (a >> b[4:0]);
				3'd6: data = a | b;
				default: data = a & b;
			endcase
		end
		else
			valid = 1'b0;
		if (valid && (rd != 5'd0))
			modelRegs[rd] = data;
		return valid;
	endfunction

	function automatic logic [4:0] pickRd();
		logic [31:0] r;
		r = nextRand();
		return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
	endfunction

	// Source register that avoids the rd of the last `window` instructions
	function automatic logic [4:0] pickSrc(input int window);
		logic [31:0] r;
		logic [4:0] src;
		src = 5'd0;
		for (int t = 0; t < 8; t++)
		begin
			r = nextRand();
			if ((r[4:0] == 5'd0) || ((r[4:0] != lastRd[0]) &&
				((window < 2) || (r[4:0] != lastRd[1]))))
			begin
				src = r[4:0];
				break;
			end
		end
		return src;
	endfunction

	function automatic logic [31:0] makeOp(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		logic [31:0] r;
		logic [6:0] f7;
		r = nextRand();
		f7 = (((r[2:0] == 3'd0) || (r[2:0] == 3'd5)) && r[3]) ? 7'h20 : 7'h00;
		return {f7, rs2, rs1, r[2:0], rd, coreLitePkg::OPC_OP};
	endfunction

	function automatic logic [31:0] makeImm(input logic [4:0] rd, input logic [4:0] rs1);
		logic [31:0] r;
		logic [31:0] ins;
		logic [6:0] f7;
		r = nextRand();
		f7 = ((r[2:0] == 3'd5) && r[6]) ? 7'h20 : 7'h00;
		if (r[5:4] == 2'b00)
			ins = {r[31:12], rd, coreLitePkg::OPC_LUI};
		else if ((r[2:0] == 3'd1) || (r[2:0] == 3'd5))
			ins = {f7, r[11:7], rs1, r[2:0], rd, coreLitePkg::OPC_OPIMM};	// Shamt 0..31
		else
			ins = {r[31:20], rs1, r[2:0], rd, coreLitePkg::OPC_OPIMM};
		return ins;
	endfunction

	function automatic logic [31:0] makeIllegal();
		logic [31:0] r;
		logic [31:0] ins;
		r = nextRand();
		case (r[1:0])
			2'd0: ins = {r[31:7], 7'b0000011};	// Load
			2'd1: ins = {r[31:7], 7'b1100011};	// Branch
			2'd2: ins = {r[31:7], 7'b0010111};	// AUIPC
			default: ins = {7'h01, r[24:7], coreLitePkg::OPC_OP};	// M extension funct7
		endcase
		return ins;
	endfunction

	function automatic logic [31:0] genInstr(input int phase, output string tag);
		logic [31:0] r;
		logic [4:0] rd, rs1;
		logic [31:0] ins;
		r = nextRand();
		rd = pickRd();
		case (phase)
			0:
			begin
				tag = "imm";
				ins = makeImm(rd, pickSrc(2));
			end
			1:
			begin
				tag = "op";
				ins = makeOp(rd, pickSrc(2), pickSrc(2));
			end
			2:
			begin
				tag = "raw chain";
				if (rd == lastRd[0])
					rd = (rd == 5'd31) ? 5'd1 : rd + 5'd1;
				// Producer two slots back is read through the write-through path
				rs1 = (lastRd[1] == lastRd[0]) ? 5'd0 : lastRd[1];
				ins = r[0] ? makeOp(rd, rs1, pickSrc(1)) : makeImm(rd, rs1);
			end
			3:
			begin
				tag = "x0 and illegal";
				case (r[2:0])
					3'd0, 3'd1: ins = makeOp(5'd0, pickSrc(2), pickSrc(2));
					3'd2: ins = makeImm(rd, 5'd0);
					3'd3: ins = makeOp(rd, 5'd0, pickSrc(2));
					3'd4, 3'd5: ins = makeIllegal();
					default: ins = makeOp(rd, pickSrc(2), pickSrc(2));
				endcase
			end
			default:
			begin
				tag = "mixed";
				ins = r[1] ? makeOp(rd, pickSrc(2), pickSrc(2)) : makeImm(rd, pickSrc(2));
			end
		endcase
		return ins;
	endfunction

	task automatic sendInstr(input logic [31:0] ins, input string tag);
		logic [4:0] rd;
		logic [31:0] data;
		@(posedge clk);
		#2;
		instrValid = 1'b1;
		instr = ins;
		if (refModel(ins, rd, data))
		begin
			expQ.push_back({rd, data});
			tagQ.push_back(tag);
		end
		lastRd[1] = lastRd[0];
		lastRd[0] = ins[11:7];
	endtask

	task automatic idleCycles(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk);
			#2;
			instrValid = 1'b0;
			instr = nextRand();	// Junk while not valid
		end
	endtask

	// Scoreboard, commits are in program order
	always @(posedge clk)
	begin
		if (nrst && commitValid)
		begin
			if (expQ.size() == 0)
				failRun("commitValid high with no instruction outstanding");
			else
			begin
				expRec = expQ.pop_front();
				expTag = tagQ.pop_front();
				checkValue({expTag, " rd"}, {27'd0, expRec[36:32]}, {27'd0, commitRd});
				checkValue({expTag, " data"}, expRec[31:0], commitData);
			end
		end
	end

	initial
	begin
		logic [31:0] r;
		logic [31:0] ins;
		string tag;
		int phaseLen;
		seed = 32'h2900;
		clk = 1'b0;
		nrst = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		lastRd[0] = '0;
		lastRd[1] = '0;
		repeat (3) @(posedge clk);
		#2;
		nrst = 1'b1;

		for (int i = 0; i < 3; i++)
		begin
			@(posedge clk);
			#2;
			checkValue("reset", 32'd0, {31'd0, commitValid});
		end

		for (int p = 0; p < 5; p++)
		begin
			phaseLen = (p < 2) ? 100 : ((p == 2) ? 80 : 60);	// 400 in total
			idleCycles(2);
			for (int i = 0; i < phaseLen; i++)
			begin
				ins = genInstr(p, tag);
				sendInstr(ins, tag);
				r = nextRand();
				if (r[2:0] == 3'd0)
					idleCycles(int'(r[4:3]) + 1);
			end
		end

		idleCycles(1);
		waitCycles = 0;
		while ((expQ.size() != 0) && (waitCycles < 20))
		begin
			@(posedge clk);
			waitCycles++;
		end
		idleCycles(4);	// A stray commit here hits an empty queue
		if (expQ.size() != 0)
			failRun("timeout waiting for outstanding commits to drain");
		else
		begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

/* filelist.f */
hw/coreLitePkg.sv
hw/regFile.sv
hw/decodeStage.sv
hw/issueStage.sv
hw/executeStage.sv
hw/coreLite.sv
dv/coreLite_sva.sv
dv/coreLiteTb.sv

/* Makefile */
TOP = coreLiteTb

.PHONY: compile run clean

compile:
	verilator --binary --assert --top-module $(TOP) -f filelist.f -o coreLiteSim

run: compile
	-./obj_dir/coreLiteSim > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@if ! grep -q "Simulation completed successfully" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
